/* source/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath word width
`define DATA_W 16

// register file geometry
`define REG_COUNT 8
`define REG_IDX_W 3

// program counter
`define PC_RESET 16'h0000
`define PC_STEP 16'd2

`endif

/* source/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

    // two-register-plus-destination format
    typedef struct packed {
        logic [4:0]            opCode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        logic [1:0]            funct;
    } rFmtView;

    // short immediate format
    typedef struct packed {
        logic [4:0]            opCode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rd;
        logic [4:0]            imm5;
    } iFmtView;

    // long immediate format, rs is also the destination
    typedef struct packed {
        logic [4:0]            opCode;
        logic [`REG_IDX_W-1:0] rs;
        logic [7:0]            imm8;
    } lFmtView;

    typedef union packed {
        rFmtView rFmt;
        iFmtView iFmt;
        lFmtView lFmt;
    } instrWord;

    typedef enum logic [1:0] {IDLE, OPERAND, EXECUTE} seqState;

endpackage

/* source/aluUnit.sv */
`timescale 1ns/1ns
`include "core_defs.svh"

module aluUnit (
    input  core_pkg::instrWord  instr,
    input  logic [`DATA_W-1:0]  rsVal,
    input  logic [`DATA_W-1:0]  rtVal,
    input  logic [`DATA_W-1:0]  pc,
    output logic [`DATA_W-1:0]  res
);
    localparam int CntW = $clog2(`DATA_W);

    logic [4:0]           opCode;
    logic [1:0]           funct;
    logic [4:0]           imm5;
    logic [7:0]           imm8;
    logic                 isXor;
    logic                 isAndn;
    logic                 isShift;
    logic                 isFlag;
    logic                 isLbi;
    logic                 isSlbi;
    logic                 isPc;
    logic                 invS;
    logic                 invT;
    logic                 selImm5;
    logic                 signImm;
    logic [`DATA_W-1:0]   immExt;
    logic [`DATA_W-1:0]   opA;
    logic [`DATA_W-1:0]   opB;
    logic                 carryIn;
    logic [`DATA_W:0]     sumFull;
    logic [`DATA_W-1:0]   sum;
    logic                 carryOut;
    logic [`DATA_W-1:0]   revRs;
    logic [1:0]           shType;
    logic [CntW-1:0]      shCnt;
    logic [2*`DATA_W-1:0] dblLeft;
    logic [2*`DATA_W-1:0] dblRight;
    logic [`DATA_W-1:0]   shRes;
    logic                 zero;
    logic                 lt;
    logic                 flagBit;

    assign opCode = instr.rFmt.opCode;
    assign funct  = instr.rFmt.funct;
    assign imm5   = instr.iFmt.imm5;
    assign imm8   = instr.lFmt.imm8;

    // op select
    assign isXor   = (opCode == 5'b01011) || (opCode == 5'b11011 && funct == 2'b10);
    assign isAndn  = (opCode == 5'b01010) || (opCode == 5'b11011 && funct == 2'b11);
    assign isShift = (opCode[4:2] == 3'b101) || (opCode == 5'b11001) || (opCode == 5'b11010);
    assign isFlag  = (opCode[4:2] == 3'b111);
    assign isLbi   = (opCode == 5'b11000);
    assign isSlbi  = (opCode == 5'b10010);
    assign isPc    = (opCode[4:3] == 2'b00);

    // operand shaping, subtract is ~x + y + 1
    assign invS    = (opCode == 5'b01000) || (opCode == 5'b11011 && funct == 2'b01);
    assign invT    = isFlag && (opCode != 5'b11111);
    assign selImm5 = (opCode[4:2] == 3'b010) || (opCode[4:2] == 3'b101)
                     || (opCode[4:2] == 3'b100);
    assign signImm = !opCode[1] || (opCode == 5'b10011);
    assign immExt  = signImm ? {{(`DATA_W-5){imm5[4]}}, imm5} : {{(`DATA_W-5){1'b0}}, imm5};

    assign opA     = invS ? ~rsVal : rsVal;
    assign opB     = selImm5 ? immExt : (invT ? ~rtVal : rtVal);
    assign carryIn = invS | invT;

    assign sumFull  = {1'b0, opA} + {1'b0, opB} + {{`DATA_W{1'b0}}, carryIn};
    assign sum      = sumFull[`DATA_W-1:0];
    assign carryOut = sumFull[`DATA_W];

    for (genvar i = 0; i < `DATA_W; i++) begin : gRev
        assign revRs[i] = rsVal[`DATA_W-1-i];
    end

    // R-format takes the kind from funct, immediate form from opcode
    assign shType   = opCode[3] ? funct : opCode[1:0];
    assign shCnt    = opB[CntW-1:0];
    assign dblLeft  = {rsVal, rsVal} << shCnt;
    assign dblRight = {rsVal, rsVal} >> shCnt;

    always_comb begin
        if (opCode == 5'b11001) begin
            shRes = revRs;
        end else begin
            case (shType)
                2'b00:   shRes = dblLeft[2*`DATA_W-1:`DATA_W];
                2'b01:   shRes = rsVal << shCnt;
                2'b10:   shRes = dblRight[`DATA_W-1:0];
                default: shRes = rsVal >> shCnt;
            endcase
        end
    end

    // compares use Rs - Rt, sign taken without overflow fixup
    assign zero = (sum == '0);
    assign lt   = sum[`DATA_W-1];

    always_comb begin
        case (opCode[1:0])
            2'b00:   flagBit = zero;
            2'b01:   flagBit = lt;
            2'b10:   flagBit = lt | zero;
            default: flagBit = carryOut;
        endcase
    end

    always_comb begin
        if (isPc) begin
            res = pc;
        end else if (isXor) begin
            res = opA ^ opB;
        end else if (isAndn) begin
            res = opA & ~opB;
        end else if (isShift) begin
            res = shRes;
        end else if (isFlag) begin
            res = {{(`DATA_W-1){1'b0}}, flagBit};
        end else if (isLbi) begin
            res = {{(`DATA_W-8){imm8[7]}}, imm8};
        end else if (isSlbi) begin
            res = {rsVal[7:0], imm8};
        end else begin
            res = sum;
        end
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ns
`include "core_defs.svh"

module regFile (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`REG_IDX_W-1:0] rdIdxA,
    input  logic [`REG_IDX_W-1:0] rdIdxB,
    output logic [`DATA_W-1:0]    rdDataA,
    output logic [`DATA_W-1:0]    rdDataB,
    input  logic                  wrEn,
    input  logic [`REG_IDX_W-1:0] wrIdx,
    input  logic [`DATA_W-1:0]    wrData
);
    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // no bypass, reads and writes never share a cycle
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    // sequencer must stay quiet while reset is held
    wrEnInReset: assert property (@(posedge clk) !arstN |-> !wrEn)
        else $error("regFile write enable high during reset");

endmodule

/* source/pcCounter.sv */
`timescale 1ns/1ns
`include "core_defs.svh"

module pcCounter (
    input  logic               clk,
    input  logic               arstN,
    input  logic               advance,
    output logic [`DATA_W-1:0] pc
);

    // wraps modulo 2^DATA_W
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `PC_RESET;
        end else if (advance) begin
            pc <= pc + `PC_STEP;
        end
    end

endmodule

/* source/execSequencer.sv */
`timescale 1ns/1ns
`include "core_defs.svh"

module execSequencer (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  logic [`DATA_W-1:0]    instr,
    output logic                  busy,
    output logic                  accept,
    output core_pkg::instrWord    aluInstr,
    output logic [`REG_IDX_W-1:0] rdIdxA,
    output logic [`REG_IDX_W-1:0] rdIdxB,
    input  logic [`DATA_W-1:0]    rdDataA,
    input  logic [`DATA_W-1:0]    rdDataB,
    output logic [`DATA_W-1:0]    rsVal,
    output logic [`DATA_W-1:0]    rtVal,
    input  logic [`DATA_W-1:0]    aluRes,
    output logic                  wrEn,
    output logic [`REG_IDX_W-1:0] wrIdx,
    output logic [`DATA_W-1:0]    wrData,
    output logic [`DATA_W-1:0]    result,
    output logic                  resultValid
);
    core_pkg::seqState     state;
    core_pkg::instrWord    instrReg;
    logic                  writes;
    logic [`REG_IDX_W-1:0] dest;

    assign accept = instrValid && (state == core_pkg::IDLE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= core_pkg::IDLE;
            busy        <= 1'b0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            case (state)
                core_pkg::IDLE: begin
                    if (instrValid) begin
                        state <= core_pkg::OPERAND;
                        busy  <= 1'b1;
                    end
                end
                core_pkg::OPERAND: begin
                    state <= core_pkg::EXECUTE;
                end
                core_pkg::EXECUTE: begin
                    state       <= core_pkg::IDLE;
                    busy        <= 1'b0;
                    result      <= aluRes;
                    resultValid <= 1'b1;
                end
                default: begin
                    state <= core_pkg::IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // instruction and operands
    always_ff @(posedge clk) begin
        if (accept) begin
            instrReg <= instr;
        end
        if (state == core_pkg::OPERAND) begin
            rsVal <= rdDataA;
            rtVal <= rdDataB;
        end
    end

    // destination field sits in a different place per format
    always_comb begin
        writes = 1'b0;
        dest   = instrReg.rFmt.rd;
        casez (instrReg.rFmt.opCode)
            5'b11011, 5'b11010, 5'b111??: begin
                writes = 1'b1;
                dest   = instrReg.rFmt.rd;
            end
            5'b010??, 5'b101??, 5'b11001: begin
                writes = 1'b1;
                dest   = instrReg.iFmt.rd;
            end
            5'b11000, 5'b10010: begin
                writes = 1'b1;
                dest   = instrReg.lFmt.rs;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    assign rdIdxA   = instrReg.rFmt.rs;
    assign rdIdxB   = instrReg.rFmt.rt;
    assign aluInstr = instrReg;
    assign wrEn     = writes && (state == core_pkg::EXECUTE);
    assign wrIdx    = dest;
    assign wrData   = aluRes;

    resultPulse: assert property (@(posedge clk) disable iff (!arstN)
        resultValid |=> !resultValid)
        else $error("resultValid held longer than one cycle");

    acceptToResult: assert property (@(posedge clk) disable iff (!arstN)
        accept |-> ##3 resultValid)
        else $error("result did not follow acceptance by two edges");

    busyNotIdle: assert property (@(posedge clk) disable iff (!arstN)
        busy |-> (state != core_pkg::IDLE))
        else $error("busy high while sequencer idle");

    // the two edges after an acceptance belong to that instruction
    noAcceptBusy: assert property (@(posedge clk) disable iff (!arstN)
        accept |=> !accept ##1 !accept)
        else $error("instruction accepted while busy");

endmodule

/* source/execCore.sv */
`timescale 1ns/1ns
`include "core_defs.svh"

module execCore (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    input  logic [`DATA_W-1:0] instr,
    output logic               busy,
    output logic               resultValid,
    output logic [`DATA_W-1:0] result,
    output logic [`DATA_W-1:0] pc
);
    logic                  accept;
    core_pkg::instrWord    aluInstr;
    logic [`REG_IDX_W-1:0] rdIdxA;
    logic [`REG_IDX_W-1:0] rdIdxB;
    logic [`DATA_W-1:0]    rdDataA;
    logic [`DATA_W-1:0]    rdDataB;
    logic [`DATA_W-1:0]    rsVal;
    logic [`DATA_W-1:0]    rtVal;
    logic [`DATA_W-1:0]    aluRes;
    logic                  wrEn;
    logic [`REG_IDX_W-1:0] wrIdx;
    logic [`DATA_W-1:0]    wrData;

    execSequencer seq (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .busy        (busy),
        .accept      (accept),
        .aluInstr    (aluInstr),
        .rdIdxA      (rdIdxA),
        .rdIdxB      (rdIdxB),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .rsVal       (rsVal),
        .rtVal       (rtVal),
        .aluRes      (aluRes),
        .wrEn        (wrEn),
        .wrIdx       (wrIdx),
        .wrData      (wrData),
        .result      (result),
        .resultValid (resultValid)
    );

    pcCounter pcCnt (
        .clk     (clk),
        .arstN   (arstN),
        .advance (accept),
        .pc      (pc)
    );

    regFile regs (
        .clk     (clk),
        .arstN   (arstN),
        .rdIdxA  (rdIdxA),
        .rdIdxB  (rdIdxB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrIdx   (wrIdx),
        .wrData  (wrData)
    );

    // pc is already advanced when the ALU sees it
    aluUnit alu (
        .instr (aluInstr),
        .rsVal (rsVal),
        .rtVal (rtVal),
        .pc    (pc),
        .res   (aluRes)
    );

endmodule

/* test/execCore_tb.sv */
`timescale 1ns/1ns
`include "core_defs.svh"

module execCore_tb;
    localparam int ClkPeriod   = 40;
    localparam int ResetCycles = 5;
    localparam int RandomCount = 300;
    localparam int TotalInstr  = 2 * `REG_COUNT + RandomCount;
    localparam int ResultLimit = 8;
    localparam longint WatchdogNs = longint'(ClkPeriod) * (ResetCycles + 6 * TotalInstr);

    logic               clk;
    logic               arstN;
    logic               instrValid;
    logic [`DATA_W-1:0] instr;
    logic               busy;
    logic               resultValid;
    logic [`DATA_W-1:0] result;
    logic [`DATA_W-1:0] pc;

    logic [31:0]        lfsrState;
    logic [`DATA_W-1:0] modelRegs [`REG_COUNT];
    logic [`DATA_W-1:0] pcModel;
    int                 checkCount;
    int                 mismatchCount;
    int                 failCount;

    execCore uut (
        .clk         (clk),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result),
        .pc          (pc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic drawBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = nextLfsr(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    // kind: 00 rotl, 01 shl, 10 rotr, 11 shr logical
    function automatic logic [15:0] shiftBits(input logic [15:0] v, input logic [1:0] kind,
                                              input logic [3:0] count);
        logic [15:0] r;
        r = v;
        for (int i = 0; i < int'(count); i++) begin
            case (kind)
                2'b00:   r = {r[14:0], r[15]};
                2'b01:   r = {r[14:0], 1'b0};
                2'b10:   r = {r[0], r[15:1]};
                default: r = {1'b0, r[15:1]};
            endcase
        end
        return r;
    endfunction

    function automatic logic [15:0] reverseBits(input logic [15:0] v);
        logic [15:0] r;
        for (int i = 0; i < 16; i++) begin
            r[i] = v[15 - i];
        end
        return r;
    endfunction

    function automatic logic [15:0] modelAlu(input logic [15:0] w, input logic [15:0] a,
                                             input logic [15:0] b, input logic [15:0] pcNow);
        logic [15:0] sImm5;
        logic [15:0] zImm5;
        logic [15:0] diff;
        logic [16:0] wide;
        sImm5 = {{11{w[4]}}, w[4:0]};
        zImm5 = {11'd0, w[4:0]};
        diff  = a - b;
        wide  = {1'b0, a} + {1'b0, b};
        casez (w[15:11])
            5'b00???: return pcNow;
            5'b01000: return sImm5 - a;
            5'b01001: return a + sImm5;
            5'b01010: return a & ~zImm5;
            5'b01011: return a ^ zImm5;
            5'b10010: return {a[7:0], w[7:0]};
            5'b100??: return a + sImm5;
            5'b101??: return shiftBits(a, w[12:11], w[3:0]);
            5'b11000: return {{8{w[7]}}, w[7:0]};
            5'b11001: return reverseBits(a);
            5'b11010: return shiftBits(a, w[1:0], b[3:0]);
            5'b11011: begin
                case (w[1:0])
                    2'b00:   return a + b;
                    2'b01:   return b - a;
                    2'b10:   return a ^ b;
                    default: return a & ~b;
                endcase
            end
            5'b11100: return {15'd0, diff == 16'd0};
            5'b11101: return {15'd0, diff[15]};
            5'b11110: return {15'd0, diff[15] | (diff == 16'd0)};
            5'b11111: return {15'd0, wide[16]};
            default:  return 16'h0000;
        endcase
    endfunction

    // -1 when the opcode writes nothing
    function automatic int destReg(input logic [15:0] w);
        casez (w[15:11])
            5'b11011, 5'b11010, 5'b111??: return int'(w[4:2]);
            5'b010??, 5'b101??, 5'b11001: return int'(w[7:5]);
            5'b11000, 5'b10010:           return int'(w[10:8]);
            default:                      return -1;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            mismatchCount++;
            $display("Mismatch %s: expected 0x%h, actual 0x%h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checkCount++;
        assert (cond === 1'b1) else begin
            failCount++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic reportCounts();
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 checkCount, mismatchCount, failCount);
    endtask

    // issue one instruction, optionally strobing again while busy
    task automatic runInstr(input logic [15:0] word, input logic strobeWhileBusy,
                            input logic [15:0] junk, input string name);
        logic [15:0] expected;
        int          dest;
        int          waited;
        int          cycles;
        logic        seen;
        waited = 0;
        while (busy && waited < ResultLimit) begin
            @(negedge clk);
            waited++;
        end
        expectTrue(!busy, "busy never dropped before issuing an instruction");
        @(posedge clk);
        instr      <= word;
        instrValid <= 1'b1;
        // accepting edge
        @(posedge clk);
        pcModel  = pcModel + `PC_STEP;
        expected = modelAlu(word, modelRegs[word[10:8]], modelRegs[word[7:5]], pcModel);
        dest     = destReg(word);
        instr      <= junk;
        instrValid <= strobeWhileBusy;
        @(negedge clk);
        expectTrue(busy, "busy low right after an accepted instruction");
        expectTrue(!resultValid, "resultValid high in the accepting cycle");
        compareValue({name, " pc"}, pcModel, pc);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < ResultLimit) begin
            @(posedge clk);
            instrValid <= 1'b0;
            @(negedge clk);
            cycles++;
            if (resultValid) begin
                seen = 1'b1;
            end else begin
                expectTrue(busy, "busy dropped before the result arrived");
            end
        end
        expectTrue(seen, "no resultValid pulse after an accepted instruction");
        compareValue({name, " latency"}, 16'd2, 16'(cycles));
        compareValue(name, expected, result);
        expectTrue(!busy, "busy still high when the result arrived");
        if (dest >= 0) begin
            modelRegs[dest] = expected;
        end
        @(negedge clk);
        expectTrue(!resultValid, "resultValid held longer than one cycle");
        compareValue({name, " pc hold"}, pcModel, pc);
        compareValue({name, " result hold"}, expected, result);
    endtask

    initial begin
        #(WatchdogNs);
        $display("Error: watchdog expired after %0d ns, the DUT stopped responding", WatchdogNs);
        reportCounts();
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [15:0] word;
        logic [15:0] pick;
        logic [15:0] junk;
        logic        strobe;
        arstN         = 1'b0;
        instrValid    = 1'b0;
        instr         = '0;
        lfsrState     = 32'h361b28cf;
        pcModel       = `PC_RESET;
        checkCount    = 0;
        mismatchCount = 0;
        failCount     = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end

        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        compareValue("reset pc", `PC_RESET, pc);
        compareValue("reset result", 16'h0000, result);
        expectTrue(!busy, "busy high after reset");
        expectTrue(!resultValid, "resultValid high after reset");

        // fill every register with lbi
        for (int r = 0; r < `REG_COUNT; r++) begin
            drawBits(8, pick);
            drawBits(16, junk);
            word = {5'b11000, 3'(r), pick[7:0]};
            runInstr(word, 1'b0, junk, "lbi load");
        end

        for (int n = 0; n < RandomCount; n++) begin
            // 011xx is not part of the instruction set
            do begin
                drawBits(5, pick);
            end while (pick[4:2] == 3'b011);
            word[15:11] = pick[4:0];
            drawBits(11, pick);
            word[10:0] = pick[10:0];
            drawBits(2, pick);
            strobe = (pick[1:0] == 2'b00);
            drawBits(16, junk);
            runInstr(word, strobe, junk, $sformatf("random op %05b", word[15:11]));
        end

        // address op with zero offset reads a register back
        for (int r = 0; r < `REG_COUNT; r++) begin
            word = {5'b10000, 3'(r), 3'b000, 5'b00000};
            runInstr(word, 1'b1, 16'hffff, $sformatf("readback r%0d", r));
        end

        reportCounts();
        if (mismatchCount == 0 && failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+source
source/core_pkg.sv
source/aluUnit.sv
source/regFile.sv
source/pcCounter.sv
source/execSequencer.sv
source/execCore.sv
test/execCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module execCore_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VexecCore_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "All tests passed!"; then
    exit 0
fi
exit 1
